// ==== include/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

// set index width, 16 sets by default
`define ICACHE_INDEX_W 4

// one word per line, so the tag is everything above the index
`define ICACHE_TAG_W (30 - `ICACHE_INDEX_W)

// word handed back for a flushed fetch
// andi r0, r0, 0
`define ICACHE_NOP 32'h0340_0000

`endif

// ==== hw/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    typedef logic [31:0]                 fetch_addr_t;
    typedef logic [31:0]                 inst_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  set_idx_t;
    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;

    // one bit per way, bit 1 is way 1
    typedef logic [1:0]                  way_vec_t;

    // pipeline control towards the cache
    typedef struct packed {
        logic stall;
        logic flush;
    } pipe_ctrl_t;

    // memory side returns
    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        inst_t rdata;
    } mem_resp_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_wait,
        stall_hold,
        flush
    } icache_state_e;

endpackage

// ==== hw/icache_ctrl_fsm.sv ====
`timescale 1ns/100ps

module icache_ctrl_fsm import icache_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       fetch_valid,
    input  pipe_ctrl_t ctrl,
    output logic       fetch_ready,
    output logic       resp_valid,
    output logic       mem_req,
    input  mem_resp_t  mem_resp,
    input  way_vec_t   hit,
    input  logic       victim,
    output logic       rbuf_we,
    output logic       rd_en,
    output way_vec_t   refill_we,
    output logic       use_valid,
    output logic       use_way,
    output logic       sel_way,
    output logic       sel_return,
    output logic       send_nop
);

    icache_state_e state;
    icache_state_e next_state;
    logic          rstn_q;
    logic          ready_c;
    logic          accept;
    logic          hit_any;

    assign hit_any = |hit;

    // first cycle out of reset takes nothing
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_q <= 1'b0;
        end else begin
            rstn_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // acceptance
    //////////////////////////////////////////////////

    // states in which a new fetch can enter
    always_comb begin
        case (state)
            idle:       ready_c = !ctrl.stall;
            lookup:     ready_c = !ctrl.stall && !ctrl.flush && hit_any;
            miss_wait:  ready_c = mem_resp.data_ok && !ctrl.stall;
            stall_hold: ready_c = !ctrl.stall;
            flush:      ready_c = !ctrl.flush && !ctrl.stall;
            default:    ready_c = 1'b0;
        endcase
    end

    assign fetch_ready = ready_c && rstn_q;
    assign accept      = fetch_valid && fetch_ready;

    // buffer and array read move together with acceptance
    assign rbuf_we = accept;
    assign rd_en   = accept;

    //////////////////////////////////////////////////
    // state register and next state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                next_state = accept ? lookup : idle;
            end
            lookup: begin
                // stall wins over flush, flush wins over a miss
                if (ctrl.stall) begin
                    next_state = lookup;
                end else if (ctrl.flush) begin
                    next_state = flush;
                end else if (!hit_any) begin
                    next_state = miss_req;
                end else begin
                    next_state = accept ? lookup : idle;
                end
            end
            miss_req: begin
                next_state = mem_resp.addr_ok ? miss_wait : miss_req;
            end
            miss_wait: begin
                if (!mem_resp.data_ok) begin
                    next_state = miss_wait;
                end else if (ctrl.stall) begin
                    next_state = stall_hold;
                end else begin
                    next_state = accept ? lookup : idle;
                end
            end
            stall_hold: begin
                if (ctrl.stall) begin
                    next_state = stall_hold;
                end else begin
                    next_state = accept ? lookup : idle;
                end
            end
            flush: begin
                if (ctrl.flush) begin
                    next_state = flush;
                end else begin
                    next_state = accept ? lookup : idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // output decode
    //////////////////////////////////////////////////

    always_comb begin
        resp_valid = 1'b0;
        mem_req    = 1'b0;
        refill_we  = '0;
        use_valid  = 1'b0;
        use_way    = 1'b0;
        sel_way    = 1'b0;
        sel_return = 1'b0;
        send_nop   = 1'b0;
        case (state)
            lookup: begin
                case (next_state)
                    flush: begin
                        resp_valid = 1'b1;
                        send_nop   = 1'b1;
                    end
                    lookup, idle: begin
                        // lookup to lookup under stall is a hold, not a hit
                        if (!ctrl.stall) begin
                            resp_valid = 1'b1;
                            use_valid  = 1'b1;
                            use_way    = hit[1];
                            sel_way    = hit[1];
                        end
                    end
                    default: begin
                    end
                endcase
            end
            miss_req: begin
                mem_req = 1'b1;
            end
            miss_wait: begin
                if (mem_resp.data_ok) begin
                    // fill the lru victim and forward the word
                    refill_we  = victim ? 2'b10 : 2'b01;
                    use_valid  = 1'b1;
                    use_way    = victim;
                    sel_return = 1'b1;
                    resp_valid = (next_state != stall_hold);
                end
            end
            stall_hold: begin
                sel_return = 1'b1;
                resp_valid = (next_state != stall_hold);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/icache_req_buf.sv ====
`timescale 1ns/100ps

`include "icache_config.svh"

module icache_req_buf import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        rbuf_we,
    input  fetch_addr_t fetch_addr,
    output fetch_addr_t req_addr,
    output set_idx_t    rd_idx,
    output set_idx_t    wr_idx,
    output tag_t        req_tag
);

    // byte offset is not kept
    logic [29:0] word_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_q <= '0;
        end else if (rbuf_we) begin
            word_q <= fetch_addr[31:2];
        end
    end

    // word aligned, also the refill address
    assign req_addr = {word_q, 2'b00};

    // array read uses the incoming index
    assign rd_idx  = fetch_addr[2 +: `ICACHE_INDEX_W];
    assign wr_idx  = word_q[0 +: `ICACHE_INDEX_W];
    assign req_tag = word_q[29 -: `ICACHE_TAG_W];

endmodule

// ==== hw/icache_tagv_array.sv ====
`timescale 1ns/100ps

module icache_tagv_array import icache_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     rd_en,
    input  set_idx_t rd_idx,
    input  tag_t     req_tag,
    input  set_idx_t wr_idx,
    input  way_vec_t refill_we,
    output way_vec_t hit
);

    localparam int SETS = 1 << $bits(set_idx_t);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t            tag_mem [SETS];
        logic [SETS-1:0] vld_q;
        tag_t            rd_tag_q;
        logic            rd_vld_q;
        logic            bypass;

        // a fetch taken in the refill cycle may read the set being filled
        assign bypass = refill_we[w] && (rd_idx == wr_idx);

        always_ff @(posedge clk) begin
            if (refill_we[w]) begin
                tag_mem[wr_idx] <= req_tag;
            end
            if (rd_en) begin
                rd_tag_q <= bypass ? req_tag : tag_mem[rd_idx];
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                vld_q    <= '0;
                rd_vld_q <= 1'b0;
            end else begin
                if (refill_we[w]) begin
                    vld_q[wr_idx] <= 1'b1;
                end
                if (rd_en) begin
                    rd_vld_q <= bypass || vld_q[rd_idx];
                end
            end
        end

        // compare against the buffered tag
        assign hit[w] = rd_vld_q && (rd_tag_q == req_tag);
    end

endmodule

// ==== hw/icache_data_array.sv ====
`timescale 1ns/100ps

`include "icache_config.svh"

module icache_data_array import icache_pkg::*; (
    input  logic     clk,
    input  logic     rd_en,
    input  set_idx_t rd_idx,
    input  set_idx_t wr_idx,
    input  way_vec_t refill_we,
    input  inst_t    refill_data,
    input  logic     sel_way,
    input  logic     sel_return,
    input  logic     send_nop,
    output inst_t    resp_inst
);

    localparam int SETS = 1 << $bits(set_idx_t);

    inst_t way_word [2];
    inst_t ret_q;

    for (genvar w = 0; w < 2; w++) begin : g_way
        inst_t word_mem [SETS];
        inst_t rd_q;

        always_ff @(posedge clk) begin
            if (refill_we[w]) begin
                word_mem[wr_idx] <= refill_data;
            end
            // write-first when the same set is read and filled
            if (rd_en) begin
                rd_q <= (refill_we[w] && (rd_idx == wr_idx)) ? refill_data : word_mem[rd_idx];
            end
        end

        assign way_word[w] = rd_q;
    end

    // copy of the refill word for a response held by stall
    always_ff @(posedge clk) begin
        if (|refill_we) begin
            ret_q <= refill_data;
        end
    end

    always_comb begin
        if (send_nop) begin
            resp_inst = `ICACHE_NOP;
        end else if (sel_return) begin
            resp_inst = (|refill_we) ? refill_data : ret_q;
        end else begin
            resp_inst = way_word[sel_way];
        end
    end

endmodule

// ==== hw/icache_lru.sv ====
`timescale 1ns/100ps

module icache_lru import icache_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  set_idx_t idx,
    input  logic     use_valid,
    input  logic     use_way,
    output logic     victim
);

    localparam int SETS = 1 << $bits(set_idx_t);

    // per set, the way touched longest ago
    logic [SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_valid) begin
            lru_q[idx] <= ~use_way;
        end
    end

    assign victim = lru_q[idx];

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    // pipeline side
    input  logic        fetch_valid,
    input  fetch_addr_t fetch_addr,
    input  pipe_ctrl_t  ctrl,
    output logic        fetch_ready,
    output logic        resp_valid,
    output inst_t       resp_inst,
    // memory side
    output logic        mem_req,
    output fetch_addr_t mem_addr,
    input  mem_resp_t   mem_resp
);

    logic     rbuf_we;
    logic     rd_en;
    way_vec_t refill_we;
    logic     use_valid;
    logic     use_way;
    logic     sel_way;
    logic     sel_return;
    logic     send_nop;
    way_vec_t hit;
    logic     victim;
    set_idx_t rd_idx;
    set_idx_t wr_idx;
    tag_t     req_tag;

    icache_ctrl_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .ctrl        (ctrl),
        .fetch_ready (fetch_ready),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .hit         (hit),
        .victim      (victim),
        .rbuf_we     (rbuf_we),
        .rd_en       (rd_en),
        .refill_we   (refill_we),
        .use_valid   (use_valid),
        .use_way     (use_way),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .send_nop    (send_nop)
    );

    icache_req_buf u_rbuf (
        .clk        (clk),
        .rstn       (rstn),
        .rbuf_we    (rbuf_we),
        .fetch_addr (fetch_addr),
        .req_addr   (mem_addr),
        .rd_idx     (rd_idx),
        .wr_idx     (wr_idx),
        .req_tag    (req_tag)
    );

    icache_tagv_array u_tagv (
        .clk       (clk),
        .rstn      (rstn),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .req_tag   (req_tag),
        .wr_idx    (wr_idx),
        .refill_we (refill_we),
        .hit       (hit)
    );

    icache_data_array u_data (
        .clk         (clk),
        .rd_en       (rd_en),
        .rd_idx      (rd_idx),
        .wr_idx      (wr_idx),
        .refill_we   (refill_we),
        .refill_data (mem_resp.rdata),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .send_nop    (send_nop),
        .resp_inst   (resp_inst)
    );

    icache_lru u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .idx       (wr_idx),
        .use_valid (use_valid),
        .use_way   (use_way),
        .victim    (victim)
    );

endmodule

// ==== dv/icache_assertions.sv ====
`timescale 1ns/100ps

module icache_assertions import icache_pkg::*; (
    input logic        clk,
    input logic        rstn,
    input pipe_ctrl_t  ctrl,
    input logic        fetch_ready,
    input logic        resp_valid,
    input logic        mem_req,
    input fetch_addr_t mem_addr,
    input mem_resp_t   mem_resp,
    input way_vec_t    refill_we
);

    // nothing moves while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rstn |-> !mem_req && !resp_valid && !fetch_ready)
        else $error("pipeline or memory port active during reset");

    //////////////////////////////////////////////////
    // memory port
    //////////////////////////////////////////////////

    req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_resp.addr_ok |=> mem_req)
        else $error("mem_req dropped before addr_ok");

    addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_resp.addr_ok |=> $stable(mem_addr))
        else $error("mem_addr changed while mem_req waits");

    // returned word lands in one way and goes out unless stalled
    refill_on_data: assert property (@(posedge clk) disable iff (!rstn)
        mem_resp.data_ok |-> $onehot(refill_we) && (resp_valid || ctrl.stall))
        else $error("returned data not written to one way or not forwarded");

    //////////////////////////////////////////////////
    // pipeline port
    //////////////////////////////////////////////////

    stall_quiet: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.stall |-> !resp_valid && !fetch_ready)
        else $error("response or acceptance under stall");

    miss_quiet: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> !resp_valid && !fetch_ready)
        else $error("response or acceptance while the refill request is open");

endmodule

// ==== dv/icache_tb.sv ====
`timescale 1ns/100ps

`include "icache_config.svh"

module icache_tb import icache_pkg::*; ();

    localparam int          NUM_REQ = 400;
    localparam int          TIMEOUT = NUM_REQ * 30 + 100;
    localparam int          SETS    = 1 << `ICACHE_INDEX_W;
    localparam logic [31:0] MEM_KEY = 32'h6B1D_0F3A;

    // an accepted fetch still waiting for its response
    typedef struct packed {
        fetch_addr_t addr;
        logic        hit;
        logic        mem_seen;
        logic [31:0] cyc;
    } pend_t;

    logic        clk;
    logic        rstn;
    logic        fetch_valid;
    fetch_addr_t fetch_addr;
    pipe_ctrl_t  ctrl;
    logic        fetch_ready;
    logic        resp_valid;
    inst_t       resp_inst;
    logic        mem_req;
    fetch_addr_t mem_addr;
    mem_resp_t   mem_resp;

    logic [31:0] rng;
    pend_t       pend [$];
    int          cyc;
    int          n_acc;
    int          run_cycles;
    logic        mem_req_prev;
    logic        flush_hold;
    logic        mem_busy;
    int          mem_wait;
    fetch_addr_t mem_line;

    // reference copy of tags, valid bits and lru
    tag_t        m_tag [2][SETS];
    logic        m_vld [2][SETS];
    logic        m_lru [SETS];

    icache_top UUT (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .ctrl        (ctrl),
        .fetch_ready (fetch_ready),
        .resp_valid  (resp_valid),
        .resp_inst   (resp_inst),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_resp    (mem_resp)
    );

    bind icache_top icache_assertions u_assertions (
        .clk         (clk),
        .rstn        (rstn),
        .ctrl        (ctrl),
        .fetch_ready (fetch_ready),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_resp    (mem_resp),
        .refill_we   (refill_we)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // memory content is tied to the word address
    function automatic inst_t mem_word(input fetch_addr_t addr);
        return {addr[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    // three tags over four sets give more lines than ways
    function automatic fetch_addr_t pick_addr();
        logic [31:0] r;
        tag_t        tg;
        r  = next_rand();
        tg = tag_t'(32'h0001_2340 + (r[1:0] % 3) * 32'h41);
        return {tg, set_idx_t'(r[3:2]), r[5:4]};
    endfunction

    function automatic logic model_hit(input fetch_addr_t addr);
        set_idx_t idx;
        logic     found;
        idx   = addr[2 +: `ICACHE_INDEX_W];
        found = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_vld[w][idx] && m_tag[w][idx] == addr[31 -: `ICACHE_TAG_W]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic model_update(input fetch_addr_t addr, input logic was_hit);
        set_idx_t idx;
        tag_t     tg;
        logic     vic;
        idx = addr[2 +: `ICACHE_INDEX_W];
        tg  = addr[31 -: `ICACHE_TAG_W];
        vic = m_lru[idx];
        if (was_hit) begin
            for (int w = 0; w < 2; w++) begin
                if (m_vld[w][idx] && m_tag[w][idx] == tg) begin
                    m_lru[idx] = (w == 0);
                end
            end
        end else begin
            m_tag[vic][idx] = tg;
            m_vld[vic][idx] = 1'b1;
            m_lru[idx]      = !vic;
        end
    endtask

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // addr_ok after a random wait, data_ok a few cycles later
    task automatic drive_memory();
        logic [31:0] r;
        r                = next_rand();
        mem_resp.addr_ok = 1'b0;
        mem_resp.data_ok = 1'b0;
        mem_resp.rdata   = next_rand();
        if (!mem_busy) begin
            if (mem_req && r[1:0] != 2'b00) begin
                mem_resp.addr_ok = 1'b1;
                mem_line         = mem_addr;
                mem_wait         = r[4:2] % 5;
                mem_busy         = 1'b1;
            end
        end else if (mem_wait == 0) begin
            mem_resp.data_ok = 1'b1;
            mem_resp.rdata   = mem_word(mem_line);
            mem_busy         = 1'b0;
        end else begin
            mem_wait--;
        end
    endtask

    //////////////////////////////////////////////////
    // per cycle checks
    //////////////////////////////////////////////////

    task automatic sample_cycle();
        pend_t head;
        pend_t entry;
        if (ctrl.stall) begin
            check_value("resp_valid", resp_valid, 1'b0);
            check_value("fetch_ready", fetch_ready, 1'b0);
        end
        // flush state holds off the pipeline
        if (flush_hold && ctrl.flush) begin
            check_value("fetch_ready", fetch_ready, 1'b0);
            check_value("resp_valid", resp_valid, 1'b0);
        end else begin
            flush_hold = 1'b0;
        end
        if (mem_req && !mem_req_prev) begin
            if (pend.size() == 0) begin
                $display("Memory request raised at %0t with no fetch pending", $time);
                stop_run();
            end else begin
                head = pend.pop_front();
                check_value("mem_req", mem_req, !head.hit);
                check_value("mem_addr", mem_addr, {head.addr[31:2], 2'b00});
                head.mem_seen = 1'b1;
                pend.push_front(head);
            end
        end
        mem_req_prev = mem_req;
        // clean lookup of a hit answers in the cycle after acceptance
        if (pend.size() != 0 && pend[0].cyc == cyc - 1 && pend[0].hit
                && !ctrl.stall && !ctrl.flush) begin
            check_value("resp_valid", resp_valid, 1'b1);
        end
        if (resp_valid) begin
            if (pend.size() == 0) begin
                $display("Response given at %0t with no fetch pending", $time);
                stop_run();
            end else begin
                head = pend.pop_front();
                if (!head.mem_seen && ctrl.flush) begin
                    check_value("resp_inst", resp_inst, `ICACHE_NOP);
                    flush_hold = 1'b1;
                end else begin
                    check_value("resp_inst", resp_inst, mem_word(head.addr));
                    check_value("mem_req issued", head.mem_seen, !head.hit);
                    model_update(head.addr, head.hit);
                end
            end
        end
        if (fetch_valid && fetch_ready) begin
            entry.addr     = fetch_addr;
            entry.hit      = model_hit(fetch_addr);
            entry.mem_seen = 1'b0;
            entry.cyc      = cyc;
            pend.push_back(entry);
            n_acc++;
        end
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            run_cycles = run_cycles + 1;
            if (run_cycles > TIMEOUT) begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
                stop_run();
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        clk          = 1'b0;
        rstn         = 1'b0;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        ctrl         = '0;
        mem_resp     = '0;
        rng          = 32'd34;
        cyc          = 0;
        n_acc        = 0;
        run_cycles   = 0;
        mem_req_prev = 1'b0;
        flush_hold   = 1'b0;
        mem_busy     = 1'b0;
        mem_wait     = 0;
        mem_line     = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[w][s] = '0;
                m_vld[w][s] = 1'b0;
            end
            m_lru[s] = 1'b0;
        end

        repeat (10) begin
            @(negedge clk);
            check_value("fetch_ready", fetch_ready, 1'b0);
            check_value("resp_valid", resp_valid, 1'b0);
            check_value("mem_req", mem_req, 1'b0);
        end
        rstn = 1'b1;
        // ready only after the first edge out of reset
        #2;
        check_value("fetch_ready", fetch_ready, 1'b0);

        // every accepted fetch gets its one response before the loop ends
        while (n_acc < NUM_REQ || pend.size() != 0) begin
            @(negedge clk);
            cyc++;
            drive_memory();
            r           = next_rand();
            fetch_valid = (n_acc < NUM_REQ) && (r[1:0] != 2'b00);
            fetch_addr  = pick_addr();
            ctrl.stall  = (next_rand() % 8 == 0);
            ctrl.flush  = (next_rand() % 10 == 0);
            #2;
            sample_cycle();
        end

        // nothing may show up in a few quiet cycles
        fetch_valid = 1'b0;
        ctrl        = '0;
        repeat (4) begin
            @(negedge clk);
            cyc++;
            drive_memory();
            #2;
            sample_cycle();
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== icache.f ====
+incdir+include
hw/icache_pkg.sv
hw/icache_ctrl_fsm.sv
hw/icache_req_buf.sv
hw/icache_tagv_array.sv
hw/icache_data_array.sv
hw/icache_lru.sv
hw/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/icache_pkg.sv
      - hw/icache_ctrl_fsm.sv
      - hw/icache_req_buf.sv
      - hw/icache_tagv_array.sv
      - hw/icache_data_array.sv
      - hw/icache_lru.sv
      - hw/icache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/icache_assertions.sv
      - dv/icache_tb.sv
